//--- blaster_consts.svh
`ifndef BLASTER_CONSTS_SVH
`define BLASTER_CONSTS_SVH

////////////////////////////////////////
// Keypad scan timing
////////////////////////////////////////

// Scan divider width
// Top two bits select the driven row, so each row gets 1024 cycles
`define KP_DIV_BITS 12

// Column sample point inside a row slot
// Late in the slot so the column lines have settled
`define KP_SAMPLE_POS 10'h3F0

////////////////////////////////////////
// Speaker tones
////////////////////////////////////////

// One half-period reload value per note
`define TONE_HALF_0 16'h2CCA
`define TONE_HALF_1 16'h27E7
`define TONE_HALF_2 16'h238D
`define TONE_HALF_3 16'h218E
`define TONE_HALF_4 16'h1DE5
`define TONE_HALF_5 16'h1AA2
`define TONE_HALF_6 16'h17BA
`define TONE_HALF_7 16'h1665

// PWM period counter width
`define PWM_CNT_BITS 16

// Low counter bits spanned by one burst
`define PWM_ON_BITS 6

`endif

//--- blaster_control.sv
`timescale 1ns/1ns

module blaster_control
	import keypad_pkg::*;
	import hv_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  key_code_t  key,
	input  logic       fire_button,
	input  logic       lt3420_done,
	input  logic       cont_n,
	input  logic [2:0] iset,
	output logic       lt3420_charge,
	output logic       dump,
	output logic       arm_led_n,
	output logic       cont_led_n,
	output logic       pwm_req,
	output logic       tone_on,
	output tone_idx_t  tone_idx
);

	logic      is_tone;
	tone_idx_t tone_ofs;

	// Tone keys are consecutive codes
	assign tone_ofs = tone_idx_t'(key - KEY_TONE0);
	assign is_tone  = (key >= KEY_TONE0) && (key <= KEY_TONE7);

	////////////////////////////////////////
	// High voltage and tone commands
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			lt3420_charge <= 1'b0;
			dump          <= 1'b0;
			pwm_req       <= 1'b0;
			tone_on       <= 1'b0;
			tone_idx      <= '0;
		end else begin
			// Closed switch or keypad forces each output
			lt3420_charge <= !iset[ISET_CHARGE] || (key == KEY_CHARGE);
			dump          <= !iset[ISET_DUMP] || (key == KEY_DUMP);
			pwm_req       <= fire_button || (key == KEY_PWM);
			tone_on       <= is_tone;
			tone_idx      <= tone_ofs;
		end
	end

	////////////////////////////////////////
	// Front panel LEDs
	////////////////////////////////////////

	// Active low drive
	always_ff @(posedge clk) begin
		arm_led_n  <= !(fire_button || lt3420_done);
		// Lit when dump switch open and a load is present
		cont_led_n <= !(iset[ISET_DUMP] && !cont_n);
	end

endmodule

//--- blaster_properties.sv
`timescale 1ns/1ns
`include "blaster_consts.svh"

module blaster_properties
	import keypad_pkg::*;
	import hv_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input key_code_t  key,
	input logic       fire_button,
	input logic       lt3420_done,
	input logic       cont_n,
	input logic [2:0] iset,
	input logic [6:0] keypad_out,
	input logic       lt3420_charge,
	input logic       dump,
	input logic       arm_led_n,
	input logic       cont_led_n,
	input logic       speaker,
	input logic       speaker_n,
	input logic       pwm
);

	int fail_count = 0;

	// Reference PWM period counter running from reset like the DUT counter
	logic [`PWM_CNT_BITS-1:0] ref_cnt;

	always_ff @(posedge clk) begin
		if (reset)
			ref_cnt <= '0;
		else
			ref_cnt <= ref_cnt + 1'b1;
	end

	task automatic flag_failure(input string what);
		$error("%s", what);
		fail_count++;
	endtask

	////////////////////////////////////////
	// Reset and speaker drive
	////////////////////////////////////////

	reset_values: assert property (@(posedge clk) $fell(reset) |->
		!speaker && speaker_n && !pwm && !lt3420_charge && !dump)
		else flag_failure("outputs not inactive after reset");

	speaker_diff: assert property (@(posedge clk) disable iff (reset) speaker_n == !speaker)
		else flag_failure("speaker_n is not the inverse of speaker");

	////////////////////////////////////////
	// Keypad row drive
	////////////////////////////////////////

	// Exactly one row pin low and the spare pins high
	row_drive: assert property (@(posedge clk) disable iff (reset) !$past(reset) |->
		$countones(~keypad_out) == 1 && keypad_out[0] && keypad_out[2] && keypad_out[4])
		else flag_failure("keypad_out does not drive exactly one row pin low");

	////////////////////////////////////////
	// Registered control outputs
	////////////////////////////////////////

	dump_rule: assert property (@(posedge clk) disable iff (reset) !$past(reset) |->
		dump == $past(!iset[ISET_DUMP] || key == KEY_DUMP))
		else flag_failure("dump does not follow iset and the DUMP key");

	charge_rule: assert property (@(posedge clk) disable iff (reset) !$past(reset) |->
		lt3420_charge == $past(!iset[ISET_CHARGE] || key == KEY_CHARGE))
		else flag_failure("lt3420_charge does not follow iset and the CHARGE key");

	arm_led_rule: assert property (@(posedge clk) disable iff (reset) !$past(reset) |->
		arm_led_n == $past(!(fire_button || lt3420_done)))
		else flag_failure("arm_led_n does not follow fire_button and lt3420_done");

	cont_led_rule: assert property (@(posedge clk) disable iff (reset) !$past(reset) |->
		cont_led_n == $past(!(iset[ISET_DUMP] && !cont_n)))
		else flag_failure("cont_led_n does not follow the continuity rule");

	// Request takes one cycle to register, the burst one more
	pwm_rule: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) && !$past(reset, 2) |->
		pwm == ($past(fire_button || key == KEY_PWM, 2) &&
			$past(ref_cnt[`PWM_CNT_BITS-1:`PWM_ON_BITS] == '0)))
		else flag_failure("pwm does not match the burst window");

endmodule

//--- blaster_top.f
+incdir+.
keypad_pkg.sv
hv_pkg.sv
key_scan.sv
blaster_control.sv
tone_gen.sv
pwm_gen.sv
blaster_top.sv
blaster_properties.sv
tb_blaster_top.sv

//--- blaster_top.sv
`timescale 1ns/1ns

module blaster_top
	import keypad_pkg::*;
	import hv_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	// Front panel
	input  logic       arm_button,
	input  logic       fire_button,
	output logic       arm_led_n,
	output logic       cont_led_n,
	output logic       speaker,
	output logic       speaker_n,
	// Active low keypad pins
	input  logic [6:0] keypad_in,
	output logic [6:0] keypad_out,
	// High voltage
	input  logic       lt3420_done,
	input  logic       cont_n,
	input  logic [2:0] iset,
	output logic       lt3420_charge,
	output logic       dump,
	output logic       pwm
);

	key_code_t key;
	logic      tone_on;
	tone_idx_t tone_idx;
	logic      pwm_req;

	key_scan key_scan_i (
		.clk        (clk),
		.reset      (reset),
		.keypad_in  (keypad_in),
		.keypad_out (keypad_out),
		.key        (key)
	);

	blaster_control blaster_control_i (
		.clk           (clk),
		.reset         (reset),
		.key           (key),
		.fire_button   (fire_button),
		.lt3420_done   (lt3420_done),
		.cont_n        (cont_n),
		.iset          (iset),
		.lt3420_charge (lt3420_charge),
		.dump          (dump),
		.arm_led_n     (arm_led_n),
		.cont_led_n    (cont_led_n),
		.pwm_req       (pwm_req),
		.tone_on       (tone_on),
		.tone_idx      (tone_idx)
	);

	tone_gen tone_gen_i (
		.clk       (clk),
		.reset     (reset),
		.tone_on   (tone_on),
		.tone_idx  (tone_idx),
		.speaker   (speaker),
		.speaker_n (speaker_n)
	);

	pwm_gen pwm_gen_i (
		.clk     (clk),
		.reset   (reset),
		.pwm_req (pwm_req),
		.pwm     (pwm)
	);

endmodule

//--- hv_pkg.sv
package hv_pkg;

	// Speaker note number
	typedef logic [2:0] tone_idx_t;

	// Positions of the iset switch bits
	// Switches read low when closed
	typedef enum logic [1:0] {
		// Tone enable switch
		ISET_TONE   = 2'd0,
		// Forces the dump output
		ISET_DUMP   = 2'd1,
		// Forces the charger on
		ISET_CHARGE = 2'd2
	} iset_bit_t;

endpackage

//--- key_scan.sv
`timescale 1ns/1ns
`include "blaster_consts.svh"

module key_scan
	import keypad_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic [6:0] keypad_in,
	output logic [6:0] keypad_out,
	output key_code_t  key
);

	logic [`KP_DIV_BITS-1:0] div;
	kp_row_t                 row_sel;
	logic                    sample_pt;
	logic                    col_low;

	// Active high latched hits
	logic [3:0] row;
	logic [2:0] col;
	// Set once a press is seen during this scan
	logic       flag;

	// Encoder terms
	logic      row_hit;
	logic      col_hit;
	kp_row_t   row_idx;
	kp_col_t   col_idx;
	key_code_t key_next;

	assign row_sel   = kp_row_t'(div[`KP_DIV_BITS-1 -: 2]);
	assign sample_pt = (div[`KP_DIV_BITS-3:0] == `KP_SAMPLE_POS);
	assign col_low   = ({keypad_in[2], keypad_in[0], keypad_in[4]} != 3'b111);

	////////////////////////////////////////
	// Row driver
	////////////////////////////////////////

	// Rows on pins 1, 6, 5, 3 and one low at a time
	always_ff @(posedge clk) begin
		if (reset) begin
			div        <= '0;
			keypad_out <= 7'h7F;
		end else begin
			div        <= div + 1'b1;
			keypad_out <= {row_sel != 2'd1, row_sel != 2'd2, 1'b1,
				row_sel != 2'd3, 1'b1, row_sel != 2'd0, 1'b1};
		end
	end

	////////////////////////////////////////
	// Column sampler
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			row  <= '0;
			col  <= '0;
			flag <= 1'b0;
		end else if (div == '0) begin
			flag <= 1'b0;
		end else if (div == '1 && !flag) begin
			// Whole scan with no press
			row <= '0;
			col <= '0;
		end else if (sample_pt && col_low) begin
			flag <= 1'b1;
			col  <= ~{keypad_in[2], keypad_in[0], keypad_in[4]};
			row  <= ~{keypad_out[3], keypad_out[5], keypad_out[6], keypad_out[1]};
		end
	end

	////////////////////////////////////////
	// Key encoder
	////////////////////////////////////////

	always_comb begin
		row_hit = |row;
		if (row[0])
			row_idx = 2'd0;
		else if (row[1])
			row_idx = 2'd1;
		else if (row[2])
			row_idx = 2'd2;
		else
			row_idx = 2'd3;

		// Right column alone wins, then middle, then left
		col_hit = 1'b1;
		if (col == 3'b001)
			col_idx = 2'd2;
		else if (col[2:1] == 2'b01)
			col_idx = 2'd1;
		else if (col[2])
			col_idx = 2'd0;
		else begin
			col_hit = 1'b0;
			col_idx = 2'd0;
		end

		key_next = KEY_NONE;
		if (row_hit && col_hit) begin
			case ({row_idx, col_idx})
				4'h0:    key_next = KEY_TONE0;
				4'h1:    key_next = KEY_TONE1;
				4'h2:    key_next = KEY_TONE2;
				4'h4:    key_next = KEY_TONE3;
				4'h5:    key_next = KEY_TONE4;
				4'h6:    key_next = KEY_TONE5;
				4'h8:    key_next = KEY_TONE6;
				4'h9:    key_next = KEY_TONE7;
				4'hA:    key_next = KEY_SPARE;
				4'hC:    key_next = KEY_CHARGE;
				4'hD:    key_next = KEY_PWM;
				4'hE:    key_next = KEY_DUMP;
				default: key_next = KEY_NONE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			key <= KEY_NONE;
		else
			key <= key_next;
	end

endmodule

//--- keypad_pkg.sv
package keypad_pkg;

	// Key code from the scanner
	// Bit 4 set means a key is held
	typedef enum logic [4:0] {
		KEY_NONE   = 5'h00,
		KEY_PWM    = 5'h10,
		KEY_TONE0  = 5'h11,
		KEY_TONE1  = 5'h12,
		KEY_TONE2  = 5'h13,
		KEY_TONE3  = 5'h14,
		KEY_TONE4  = 5'h15,
		KEY_TONE5  = 5'h16,
		KEY_TONE6  = 5'h17,
		KEY_TONE7  = 5'h18,
		KEY_SPARE  = 5'h19,
		KEY_CHARGE = 5'h1A,
		KEY_DUMP   = 5'h1B
	} key_code_t;

	// Row number of the four rows
	typedef logic [1:0] kp_row_t;

	// Column number of the three used columns
	typedef logic [1:0] kp_col_t;

endpackage

//--- pwm_gen.sv
`timescale 1ns/1ns
`include "blaster_consts.svh"

module pwm_gen (
	input  logic clk,
	input  logic reset,
	input  logic pwm_req,
	output logic pwm
);

	// Free running period counter
	logic [`PWM_CNT_BITS-1:0] cnt;
	logic                     burst;

	// High for the first 2^PWM_ON_BITS counts after each wrap
	assign burst = (cnt[`PWM_CNT_BITS-1:`PWM_ON_BITS] == '0);

	always_ff @(posedge clk) begin
		if (reset)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pwm <= 1'b0;
		else
			pwm <= pwm_req && burst;
	end

endmodule

//--- tb_blaster_top.sv
`timescale 1ns/1ns
`include "blaster_consts.svh"

module tb_blaster_top
	import keypad_pkg::*;
();

	localparam int SCAN       = 1 << `KP_DIV_BITS;
	localparam int PWM_PERIOD = 1 << `PWM_CNT_BITS;
	localparam int PWM_WIDTH  = 1 << `PWM_ON_BITS;
	localparam int EDGE_MAX   = `TONE_HALF_0 + 2;
	// Ten scans per key test, five edges per note, four periods per PWM test
	localparam int LIMIT = 12 * 10 * SCAN + 8 * 5 * EDGE_MAX + 4 * 4 * PWM_PERIOD + 20000;
	localparam int ROW_PIN [4] = '{1, 6, 5, 3};
	localparam int COL_PIN [3] = '{2, 0, 4};

	// Output selectors for wait_for
	localparam int SEL_CHARGE  = 0;
	localparam int SEL_DUMP    = 1;
	localparam int SEL_PWM     = 2;
	localparam int SEL_SPEAKER = 3;

	logic       clk;
	logic       reset;
	logic       arm_button;
	logic       fire_button;
	logic       cont_n;
	logic       lt3420_done;
	logic [2:0] iset;
	logic [6:0] keypad_in;
	logic [6:0] keypad_out;
	logic       arm_led_n;
	logic       cont_led_n;
	logic       speaker;
	logic       speaker_n;
	logic       lt3420_charge;
	logic       dump;
	logic       pwm;

	// Keypad model state
	logic    held;
	kp_row_t held_row;
	kp_col_t held_col;

	int cycle = 0;
	int errors = 0;
	int test_no = 0;
	int failed_tests = 0;
	int mark = 0;
	int seed;

	blaster_top dut_i (.*);

	bind blaster_top blaster_properties props_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle > LIMIT) begin
			$display("Timeout: run went past %0d cycles", LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Held key pulls its column low while its row is driven low
	always @(negedge clk) begin
		keypad_in <= 7'h7F;
		if (held && !keypad_out[ROW_PIN[held_row]])
			keypad_in[COL_PIN[held_col]] <= 1'b0;
	end

	function automatic int tone_half(input int n);
		case (n)
			0: return `TONE_HALF_0;
			1: return `TONE_HALF_1;
			2: return `TONE_HALF_2;
			3: return `TONE_HALF_3;
			4: return `TONE_HALF_4;
			5: return `TONE_HALF_5;
			6: return `TONE_HALF_6;
			default: return `TONE_HALF_7;
		endcase
	endfunction

	function automatic logic watched(input int sel);
		case (sel)
			SEL_CHARGE: return lt3420_charge;
			SEL_DUMP: return dump;
			SEL_PWM: return pwm;
			default: return speaker;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic expect_event(input string what, input bit seen);
		assert (seen) else begin
			$display("Gave up waiting for %s", what);
			errors++;
		end
	endtask

	task automatic skip_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_for(input int sel, input logic level, input int limit,
		output bit seen);
		int n;
		n = 0;
		while (watched(sel) !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		seen = (watched(sel) === level);
	endtask

	task automatic end_test(input string name);
		int now;
		now = errors + dut_i.props_i.fail_count;
		$display("Test %0d %s: %0d errors", test_no, name, now - mark);
		if (now != mark)
			failed_tests++;
		test_no++;
		mark = now;
	endtask

	task automatic key_output_test(input kp_row_t r, input kp_col_t c, input int sel,
		input string name);
		bit seen;
		held_row = r;
		held_col = c;
		held     = 1'b1;
		wait_for(sel, 1'b1, 3 * SCAN, seen);
		expect_event({name, " to rise"}, seen);
		skip_cycles(SCAN);
		check_value(name, 32'(watched(sel)), 32'd1);
		held = 1'b0;
		wait_for(sel, 1'b0, 3 * SCAN, seen);
		expect_event({name, " to fall"}, seen);
	endtask

	// First pulse may be cut short by the request, so measure from the next one
	task automatic pwm_pulse_test();
		bit seen;
		int rise;
		wait_for(SEL_PWM, 1'b1, PWM_PERIOD + 3 * SCAN, seen);
		expect_event("a first pwm pulse", seen);
		wait_for(SEL_PWM, 1'b0, PWM_WIDTH + 2, seen);
		wait_for(SEL_PWM, 1'b1, PWM_PERIOD, seen);
		expect_event("a second pwm pulse", seen);
		rise = cycle;
		wait_for(SEL_PWM, 1'b0, PWM_WIDTH + 2, seen);
		check_value("pwm width", 32'(cycle - rise), 32'(PWM_WIDTH));
		wait_for(SEL_PWM, 1'b1, PWM_PERIOD, seen);
		check_value("pwm spacing", 32'(cycle - rise), 32'(PWM_PERIOD));
	endtask

	initial begin
		bit          seen;
		int          last;
		int          high;
		int          total;
		logic [31:0] rnd;
		seed        = 32'h6f19_652a;
		reset       = 1'b1;
		arm_button  = 1'b0;
		fire_button = 1'b0;
		cont_n      = 1'b1;
		lt3420_done = 1'b0;
		iset        = 3'b111;
		keypad_in   = 7'h7F;
		held        = 1'b0;
		held_row    = '0;
		held_col    = '0;
		skip_cycles(5);
		reset = 1'b0;
		check_value("speaker", 32'(speaker), 32'd0);
		check_value("speaker_n", 32'(speaker_n), 32'd1);
		check_value("pwm", 32'(pwm), 32'd0);
		check_value("lt3420_charge", 32'(lt3420_charge), 32'd0);
		check_value("dump", 32'(dump), 32'd0);
		end_test("reset values");

		repeat (64) begin
			@(negedge clk);
			rnd  = $random(seed);
			iset = rnd[2:0];
		end
		end_test("iset dump and charge");

		repeat (256) begin
			@(negedge clk);
			rnd         = $random(seed);
			fire_button = rnd[0];
			lt3420_done = rnd[1];
			cont_n      = rnd[2];
			iset        = rnd[5:3];
		end
		@(negedge clk);
		fire_button = 1'b0;
		lt3420_done = 1'b0;
		cont_n      = 1'b1;
		iset        = 3'b111;
		end_test("leds");

		key_output_test(2'd3, 2'd0, SEL_CHARGE, "lt3420_charge");
		end_test("charge key");
		key_output_test(2'd3, 2'd2, SEL_DUMP, "dump");
		end_test("dump key");

		for (int n = 0; n < 8; n++) begin
			held_row = kp_row_t'(n / 3);
			held_col = kp_col_t'(n % 3);
			held     = 1'b1;
			wait_for(SEL_SPEAKER, !speaker, 2 * SCAN + EDGE_MAX, seen);
			expect_event("the first speaker edge", seen);
			last = cycle;
			for (int k = 0; k < 3; k++) begin
				wait_for(SEL_SPEAKER, !speaker, EDGE_MAX, seen);
				check_value("speaker edge gap", 32'(cycle - last), 32'(tone_half(n) + 1));
				last = cycle;
			end
			held = 1'b0;
			// Release within two scans, then the last half-period runs out
			skip_cycles(2 * SCAN + EDGE_MAX + 8);
			check_value("speaker", 32'(speaker), 32'd0);
			end_test($sformatf("tone %0d", n));
		end

		fire_button = 1'b1;
		pwm_pulse_test();
		fire_button = 1'b0;
		end_test("pwm from fire_button");

		held_row = 2'd3;
		held_col = 2'd1;
		held     = 1'b1;
		pwm_pulse_test();
		held = 1'b0;
		end_test("pwm from key");

		skip_cycles(3 * SCAN);
		high = 0;
		repeat (PWM_PERIOD + PWM_WIDTH) begin
			@(negedge clk);
			if (pwm)
				high++;
		end
		check_value("pwm high cycles", 32'(high), 32'd0);
		end_test("pwm idle");

		total = errors + dut_i.props_i.fail_count;
		$display("Tests: %0d, failed: %0d, errors: %0d", test_no, failed_tests, total);
		if (total == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- tone_gen.sv
`timescale 1ns/1ns
`include "blaster_consts.svh"

module tone_gen
	import hv_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      tone_on,
	input  tone_idx_t tone_idx,
	output logic      speaker,
	output logic      speaker_n
);

	logic [15:0] tone_cnt;
	logic [15:0] half_period;
	logic        phase;
	logic        spk_en;

	// Note table
	always_comb begin
		case (tone_idx)
			3'd0:    half_period = `TONE_HALF_0;
			3'd1:    half_period = `TONE_HALF_1;
			3'd2:    half_period = `TONE_HALF_2;
			3'd3:    half_period = `TONE_HALF_3;
			3'd4:    half_period = `TONE_HALF_4;
			3'd5:    half_period = `TONE_HALF_5;
			3'd6:    half_period = `TONE_HALF_6;
			default: half_period = `TONE_HALF_7;
		endcase
	end

	// Half-period down-counter
	// Enable is only sampled at each reload
	always_ff @(posedge clk) begin
		if (reset) begin
			tone_cnt <= '0;
			phase    <= 1'b0;
			spk_en   <= 1'b0;
		end else if (tone_cnt == '0) begin
			phase    <= !phase;
			spk_en   <= tone_on;
			tone_cnt <= tone_on ? half_period : 16'h0000;
		end else begin
			tone_cnt <= tone_cnt - 1'b1;
		end
	end

	// Differential drive doubles the swing
	assign speaker   = phase & spk_en;
	assign speaker_n = !speaker;

endmodule
